// ==== hw/div_cfg_pkg.sv ====
//////////////////////////////////////////////////
// Word width and pipeline shape of the divider
// The stage list must end in a register at step 31
//////////////////////////////////////////////////

package div_cfg_pkg;

	// Operand and result width in bits
	localparam int DIV_XLEN = 32;

	//////////////////////////////////////////////////
	// Stage placement
	//////////////////////////////////////////////////

	// Bit (DIV_XLEN-1-k) set means step k of the array ends in a register
	// One register after every fourth step gives eight balanced stages
	// Step 31 is bit 0, so the array output is always registered
	localparam logic [DIV_XLEN-1:0] DIV_STAGE_LIST = 32'h1111_1111;

	// Number of register stages inside the array
	localparam int DIV_ARRAY_STAGES = $countones(DIV_STAGE_LIST);

	// Request to response in cycles
	// One cycle for the operand register in front of the array
	// and one for the response register behind it
	localparam int DIV_LATENCY = DIV_ARRAY_STAGES + 2;

endpackage

// ==== hw/div_types_pkg.sv ====
//////////////////////////////////////////////////
// Request, sideband and response types of the divider
// Field widths follow the word width of div_cfg_pkg
//////////////////////////////////////////////////

package div_types_pkg;

	//////////////////////////////////////////////////
	// Operation
	//////////////////////////////////////////////////

	// The four divide operations of the M extension
	typedef enum logic [1:0] {
		DIV_OP_DIV  = 2'd0,
		DIV_OP_DIVU = 2'd1,
		DIV_OP_REM  = 2'd2,
		DIV_OP_REMU = 2'd3
	} div_op_e;

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	// One divide request, dividend in a and divisor in b
	typedef struct packed {
		div_op_e                          op;
		logic [div_cfg_pkg::DIV_XLEN-1:0] a;
		logic [div_cfg_pkg::DIV_XLEN-1:0] b;
	} div_req_t;

	// Flags that ride along with the magnitudes through the array
	// They tell the output stage what to pick and what to negate
	typedef struct packed {
		logic sel_rem;
		logic neg_quo;
		logic neg_rem;
	} div_side_t;

	// Result word of one request
	typedef struct packed {
		logic [div_cfg_pkg::DIV_XLEN-1:0] data;
	} div_rsp_t;

endpackage

// ==== hw/div_sign_prep.sv ====
//////////////////////////////////////////////////
// Operand register, turns signed operands into magnitudes
// The most negative value passes as its unsigned pattern
//////////////////////////////////////////////////

`timescale 1ns/1ps

module div_sign_prep (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             i_valid,
	input  div_types_pkg::div_req_t          i_req,
	output logic                             o_valid,
	output logic [div_cfg_pkg::DIV_XLEN-1:0] o_dividend,
	output logic [div_cfg_pkg::DIV_XLEN-1:0] o_divisor,
	output div_types_pkg::div_side_t         o_side
);

	logic                             op_signed;
	logic                             a_neg;
	logic                             b_neg;
	logic                             b_zero;
	logic [div_cfg_pkg::DIV_XLEN-1:0] a_mag;
	logic [div_cfg_pkg::DIV_XLEN-1:0] b_mag;
	div_types_pkg::div_side_t         side;

	//////////////////////////////////////////////////
	// Sign decode
	//////////////////////////////////////////////////

	// DIV and REM treat both operands as two's complement
	assign op_signed = (i_req.op == div_types_pkg::DIV_OP_DIV) ||
		(i_req.op == div_types_pkg::DIV_OP_REM);

	// A sign bit only counts for a signed operation
	assign a_neg  = op_signed & i_req.a[div_cfg_pkg::DIV_XLEN-1];
	assign b_neg  = op_signed & i_req.b[div_cfg_pkg::DIV_XLEN-1];
	assign b_zero = (i_req.b == '0);

	// Negation of the most negative value wraps back onto itself,
	// which is exactly its magnitude read as unsigned
	assign a_mag = a_neg ? -i_req.a : i_req.a;
	assign b_mag = b_neg ? -i_req.b : i_req.b;

	// Quotient sign is the xor of the operand signs
	// A zero divisor keeps the all-ones quotient unsigned
	// Remainder takes the sign of the dividend
	assign side.sel_rem = (i_req.op == div_types_pkg::DIV_OP_REM) ||
		(i_req.op == div_types_pkg::DIV_OP_REMU);
	assign side.neg_quo = (a_neg ^ b_neg) & ~b_zero;
	assign side.neg_rem = a_neg;

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid    <= 1'b0;
			o_dividend <= '0;
			o_divisor  <= '0;
			o_side     <= '0;
		end else begin
			o_valid    <= i_valid;
			o_dividend <= a_mag;
			o_divisor  <= b_mag;
			o_side     <= side;
		end
	end

endmodule

// ==== hw/div_array.sv ====
//////////////////////////////////////////////////
// Unrolled unsigned restoring divider, one step per quotient bit
// Latency is the number of set bits in the stage list
//////////////////////////////////////////////////

`timescale 1ns/1ps

module div_array (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             i_valid,
	input  logic [div_cfg_pkg::DIV_XLEN-1:0] i_dividend,
	input  logic [div_cfg_pkg::DIV_XLEN-1:0] i_divisor,
	input  div_types_pkg::div_side_t         i_side,
	output logic                             o_valid,
	output logic [div_cfg_pkg::DIV_XLEN-1:0] o_quotient,
	output logic [div_cfg_pkg::DIV_XLEN-1:0] o_remainder,
	output div_types_pkg::div_side_t         o_side
);

	typedef logic [div_cfg_pkg::DIV_XLEN-1:0] word_t;

	// Everything one division carries between two steps
	// part holds the partial remainder in its top bits and the
	// dividend bits not yet consumed below it
	typedef struct packed {
		logic                     valid;
		word_t                    part;
		word_t                    dvsr;
		word_t                    quo;
		div_types_pkg::div_side_t side;
	} div_stage_t;

	// Entry 0 is the array input, entry k+1 is the result of step k
	div_stage_t stg [0:div_cfg_pkg::DIV_XLEN];

	assign stg[0] = '{
		valid: i_valid,
		part:  i_dividend,
		dvsr:  i_divisor,
		quo:   '0,
		side:  i_side
	};

	//////////////////////////////////////////////////
	// Restoring steps
	//////////////////////////////////////////////////

	// Step i works on the top i+1 bits of the partial word
	// and produces quotient bit DIV_XLEN-1-i
	for (genvar i = 0; i < div_cfg_pkg::DIV_XLEN; i++) begin : g_step
		logic [i:0] step_rem;
		logic [i:0] step_dvsr;
		logic [i:0] step_diff;
		logic       dvsr_high;
		logic       step_q;
		word_t      low_mask;
		div_stage_t step_next;

		// Partial remainder so far, with the next dividend bit appended
		assign step_rem  = stg[i].part[div_cfg_pkg::DIV_XLEN-1 -: i+1];
		assign step_dvsr = stg[i].dvsr[i:0];

		// Any divisor bit above the step width makes the divisor
		// larger than every value the step can hold
		assign dvsr_high = |(stg[i].dvsr >> (i + 1));

		// A zero divisor always fits, so every quotient bit is set
		// and the dividend falls through untouched as the remainder
		assign step_q    = ~dvsr_high & (step_rem >= step_dvsr);
		assign step_diff = step_q ? (step_rem - step_dvsr) : step_rem;

		// Keep the unconsumed dividend bits below the new remainder
		assign low_mask = (word_t'(1) << (div_cfg_pkg::DIV_XLEN - 1 - i)) - word_t'(1);

		assign step_next.valid = stg[i].valid;
		assign step_next.part  = (stg[i].part & low_mask) |
			(word_t'(step_diff) << (div_cfg_pkg::DIV_XLEN - 1 - i));
		assign step_next.dvsr  = stg[i].dvsr;
		assign step_next.quo   = stg[i].quo |
			(word_t'(step_q) << (div_cfg_pkg::DIV_XLEN - 1 - i));
		assign step_next.side  = stg[i].side;

		// Steps flagged in the stage list end in a register,
		// the others chain straight into the next step
		if (div_cfg_pkg::DIV_STAGE_LIST[div_cfg_pkg::DIV_XLEN-1-i]) begin : g_reg
			div_stage_t stage_q;

			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					stage_q <= '0;
				end else begin
					stage_q <= step_next;
				end
			end

			assign stg[i+1] = stage_q;
		end else begin : g_comb
			assign stg[i+1] = step_next;
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// After the last step the whole word is the remainder
	assign o_valid     = stg[div_cfg_pkg::DIV_XLEN].valid;
	assign o_quotient  = stg[div_cfg_pkg::DIV_XLEN].quo;
	assign o_remainder = stg[div_cfg_pkg::DIV_XLEN].part;
	assign o_side      = stg[div_cfg_pkg::DIV_XLEN].side;

endmodule

// ==== hw/div_sign_fix.sv ====
//////////////////////////////////////////////////
// Response register, restores signs and picks the result
// Inputs are unsigned quotient and remainder magnitudes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module div_sign_fix (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             i_valid,
	input  logic [div_cfg_pkg::DIV_XLEN-1:0] i_quotient,
	input  logic [div_cfg_pkg::DIV_XLEN-1:0] i_remainder,
	input  div_types_pkg::div_side_t         i_side,
	output logic                             o_valid,
	output div_types_pkg::div_rsp_t          o_rsp
);

	logic [div_cfg_pkg::DIV_XLEN-1:0] quo_fixed;
	logic [div_cfg_pkg::DIV_XLEN-1:0] rem_fixed;
	div_types_pkg::div_rsp_t          rsp;

	//////////////////////////////////////////////////
	// Sign restore
	//////////////////////////////////////////////////

	// Overflow needs no special case here
	// The magnitude of the most negative dividend over one is already
	// the right pattern and both signs match so it is not negated
	assign quo_fixed = i_side.neg_quo ? -i_quotient : i_quotient;

	// Remainder follows the dividend sign and zero stays zero
	assign rem_fixed = i_side.neg_rem ? -i_remainder : i_remainder;

	assign rsp.data = i_side.sel_rem ? rem_fixed : quo_fixed;

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid <= 1'b0;
			o_rsp   <= '0;
		end else begin
			o_valid <= i_valid;
			o_rsp   <= rsp;
		end
	end

endmodule

// ==== hw/div_unit_top.sv ====
//////////////////////////////////////////////////
// Pipelined divide unit, one request per cycle, no stall
// Response follows its request after DIV_LATENCY cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module div_unit_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_valid,
	input  div_types_pkg::div_req_t i_req,
	output logic                    o_valid,
	output div_types_pkg::div_rsp_t o_rsp
);

	// Operand register to array
	logic                             prep_valid;
	logic [div_cfg_pkg::DIV_XLEN-1:0] prep_dividend;
	logic [div_cfg_pkg::DIV_XLEN-1:0] prep_divisor;
	div_types_pkg::div_side_t         prep_side;

	// Array to response register
	logic                             arr_valid;
	logic [div_cfg_pkg::DIV_XLEN-1:0] arr_quotient;
	logic [div_cfg_pkg::DIV_XLEN-1:0] arr_remainder;
	div_types_pkg::div_side_t         arr_side;

	div_sign_prep u_prep (
		.clk        (clk),
		.rst        (rst),
		.i_valid    (i_valid),
		.i_req      (i_req),
		.o_valid    (prep_valid),
		.o_dividend (prep_dividend),
		.o_divisor  (prep_divisor),
		.o_side     (prep_side)
	);

	// Magnitudes only from here until the sign fix
	div_array u_array (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (prep_valid),
		.i_dividend  (prep_dividend),
		.i_divisor   (prep_divisor),
		.i_side      (prep_side),
		.o_valid     (arr_valid),
		.o_quotient  (arr_quotient),
		.o_remainder (arr_remainder),
		.o_side      (arr_side)
	);

	div_sign_fix u_fix (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (arr_valid),
		.i_quotient  (arr_quotient),
		.i_remainder (arr_remainder),
		.i_side      (arr_side),
		.o_valid     (o_valid),
		.o_rsp       (o_rsp)
	);

endmodule

// ==== bench/div_model.svh ====
//////////////////////////////////////////////////
// RISC-V divide results and response compare tasks
// Included inside the testbench module that owns stop_with_error
//////////////////////////////////////////////////

`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

typedef logic [div_cfg_pkg::DIV_XLEN-1:0] word_t;

// Most negative signed value and the only dividend that can overflow
localparam word_t MOST_NEG = {1'b1, {(div_cfg_pkg::DIV_XLEN-1){1'b0}}};

//////////////////////////////////////////////////
// Reference results
//////////////////////////////////////////////////

// Signed quotient rounds toward zero as the SV operator does
function automatic word_t quotient_signed(input word_t a, input word_t b);
	word_t q;
	if (b == '0) begin
		q = '1;
	end else if ((a == MOST_NEG) && (b == '1)) begin
		q = MOST_NEG;
	end else begin
		q = word_t'($signed(a) / $signed(b));
	end
	return q;
endfunction

function automatic word_t quotient_unsigned(input word_t a, input word_t b);
	return (b == '0) ? '1 : (a / b);
endfunction

// Remainder carries the sign of the dividend
function automatic word_t remainder_signed(input word_t a, input word_t b);
	word_t r;
	if (b == '0) begin
		r = a;
	end else if ((a == MOST_NEG) && (b == '1)) begin
		r = '0;
	end else begin
		r = word_t'($signed(a) % $signed(b));
	end
	return r;
endfunction

function automatic word_t remainder_unsigned(input word_t a, input word_t b);
	return (b == '0) ? a : (a % b);
endfunction

function automatic div_types_pkg::div_rsp_t expected_result(input div_types_pkg::div_req_t req);
	div_types_pkg::div_rsp_t rsp;
	case (req.op)
		div_types_pkg::DIV_OP_DIV:  rsp.data = quotient_signed(req.a, req.b);
		div_types_pkg::DIV_OP_DIVU: rsp.data = quotient_unsigned(req.a, req.b);
		div_types_pkg::DIV_OP_REM:  rsp.data = remainder_signed(req.a, req.b);
		default:                    rsp.data = remainder_unsigned(req.a, req.b);
	endcase
	return rsp;
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

// Data of one response against the model result
task automatic check_response(input div_types_pkg::div_rsp_t got,
	input div_types_pkg::div_rsp_t exp, input div_types_pkg::div_req_t req);
	if (got.data !== exp.data) begin
		$display("mismatch at %0t: %s a=%h b=%h gave %h, expected %h",
			$time, req.op.name(), req.a, req.b, got.data, exp.data);
		stop_with_error();
	end
endtask

// Responses seen so far against requests whose response is due
task automatic check_response_count(input int due, input int seen);
	if (seen > due) begin
		$display("Extra response at %0t: %0d responses seen while only %0d were due",
			$time, seen, due);
		stop_with_error();
	end else if (seen < due) begin
		$display("Missing response at %0t: %0d responses seen while %0d were due",
			$time, seen, due);
		stop_with_error();
	end
endtask

`endif

// ==== bench/tb_div_unit.sv ====
//////////////////////////////////////////////////
// Random and corner case test of the pipelined divide unit
// Every response must come exactly DIV_LATENCY cycles after its request
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_div_unit;

	`include "div_model.svh"

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 4;

	// Length of each test phase in cycles
	localparam int IDLE_START = 8;
	localparam int N_DIRECTED = 22;
	localparam int N_BURST    = 200;
	localparam int N_RANDOM   = 600;
	localparam int TAIL_IDLE  = div_cfg_pkg::DIV_LATENCY + 2;
	localparam int N_SLOTS    = IDLE_START + N_DIRECTED + N_BURST + N_RANDOM +
		div_cfg_pkg::DIV_LATENCY + TAIL_IDLE;

	// All slots plus reset, the last response and some slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_SLOTS + div_cfg_pkg::DIV_LATENCY + 100;

	// One request in flight with its expected answer
	typedef struct packed {
		div_types_pkg::div_req_t req;
		div_types_pkg::div_rsp_t rsp;
	} pending_t;

	logic                    clk;
	logic                    rst;
	logic                    i_valid;
	div_types_pkg::div_req_t i_req;
	logic                    o_valid;
	div_types_pkg::div_rsp_t o_rsp;

	int       seed;
	int       cycle_cnt = 0;
	int       seen_cnt = 0;
	int       due_idx = 0;
	int       sent_cycles[$];
	pending_t pend_q[$];

	div_unit_top i_dut (
		.clk     (clk),
		.rst     (rst),
		.i_valid (i_valid),
		.i_req   (i_req),
		.o_valid (o_valid),
		.o_rsp   (o_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Cycle counter that also acts as the watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run hung: still going after %0d cycles", cycle_cnt);
			stop_with_error();
		end
	end

	task automatic stop_with_error();
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first error");
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Operand classes are weighted toward the corner cases
	task automatic draw_request(output div_types_pkg::div_req_t req);
		int class_sel;
		class_sel = $unsigned($random(seed)) % 10;
		req.op = div_types_pkg::div_op_e'($random(seed) & 3);
		req.a  = $random(seed);
		req.b  = $random(seed);
		case (class_sel)
			5, 6: begin
				// Small values of either sign
				req.a = word_t'($random(seed) % 17);
				req.b = word_t'($random(seed) % 17);
			end
			7: req.b = '0;
			8: req.b = '1;
			9: req.a = MOST_NEG;
			default: ;
		endcase
	endtask

	// Sample the response of the current cycle before new inputs go out
	task automatic collect_output();
		pending_t entry;
		while ((due_idx < sent_cycles.size()) &&
			(sent_cycles[due_idx] + div_cfg_pkg::DIV_LATENCY <= cycle_cnt)) begin
			due_idx++;
		end
		if (o_valid === 1'b1) begin
			seen_cnt++;
		end
		check_response_count(due_idx, seen_cnt);
		if (o_valid === 1'b1) begin
			entry = pend_q.pop_front();
			check_response(o_rsp, entry.rsp, entry.req);
		end
	endtask

	// One clock cycle
	// An idle slot still drives junk operands
	task automatic run_cycle(input logic strobe, input div_types_pkg::div_req_t req);
		pending_t entry;
		@(posedge clk);
		#DRIVE_DELAY;
		collect_output();
		i_valid = strobe;
		i_req   = req;
		if (strobe) begin
			entry.req = req;
			entry.rsp = expected_result(req);
			pend_q.push_back(entry);
			sent_cycles.push_back(cycle_cnt);
		end
	endtask

	// Zero divisor, overflow and divisor of -1 cases sent back to back
	task automatic run_directed();
		div_types_pkg::div_req_t req;
		word_t                   dividends [4];
		dividends = '{word_t'(32'h1234_5678), word_t'(0), MOST_NEG, '1};
		for (int op = 0; op < 4; op++) begin
			for (int k = 0; k < 4; k++) begin
				req.op = div_types_pkg::div_op_e'(op);
				req.a  = dividends[k];
				req.b  = '0;
				run_cycle(1'b1, req);
			end
		end
		for (int op = 0; op < 4; op++) begin
			req.op = div_types_pkg::div_op_e'(op);
			req.a  = MOST_NEG;
			req.b  = '1;
			run_cycle(1'b1, req);
		end
		req.a  = word_t'(-7);
		req.b  = '1;
		req.op = div_types_pkg::DIV_OP_DIV;
		run_cycle(1'b1, req);
		req.op = div_types_pkg::DIV_OP_REM;
		run_cycle(1'b1, req);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		div_types_pkg::div_req_t req;
		logic                    strobe;
		seed    = 32'h20d2;
		rst     = 1'b1;
		i_valid = 1'b0;
		i_req   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		// Quiet start where no response may appear
		for (int n = 0; n < IDLE_START; n++) begin
			draw_request(req);
			run_cycle(1'b0, req);
		end

		run_directed();

		// A strobe on every cycle
		for (int n = 0; n < N_BURST; n++) begin
			draw_request(req);
			run_cycle(1'b1, req);
		end

		// About three of four cycles carry a request
		for (int n = 0; n < N_RANDOM; n++) begin
			draw_request(req);
			strobe = (($random(seed) & 3) != 0);
			run_cycle(strobe, req);
		end

		while (pend_q.size() != 0) begin
			draw_request(req);
			run_cycle(1'b0, req);
		end

		// Late or spurious responses would show up here
		for (int n = 0; n < TAIL_IDLE; n++) begin
			draw_request(req);
			run_cycle(1'b0, req);
		end

		if ((pend_q.size() == 0) && (seen_cnt == sent_cycles.size())) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Run ended with %0d of %0d responses seen",
				seen_cnt, sent_cycles.size());
			stop_with_error();
		end
	end

endmodule

// ==== list.f ====
+incdir+bench
hw/div_cfg_pkg.sv
hw/div_types_pkg.sv
hw/div_sign_prep.sv
hw/div_array.sv
hw/div_sign_fix.sv
hw/div_unit_top.sv
bench/tb_div_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_div_unit
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
